// ==== exec_alu.sv ====
// Single-step ALU for the execution subsystem
// Add, subtract, bitwise logic and signed set-less-than, all combinational

`timescale 1ns/1ps

module exec_alu (
  input  rv_isa_pkg::alu_op_e         op_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] a_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] b_i,
  output logic [rv_cfg_pkg::XLEN-1:0] y_o
);

  // Signed compare result for SLT
  logic lt_signed;

  assign lt_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      rv_isa_pkg::ALU_ADD: begin
        y_o = a_i + b_i;
      end
      rv_isa_pkg::ALU_SUB: begin
        y_o = a_i - b_i;
      end
      rv_isa_pkg::ALU_AND: begin
        y_o = a_i & b_i;
      end
      rv_isa_pkg::ALU_OR: begin
        y_o = a_i | b_i;
      end
      rv_isa_pkg::ALU_XOR: begin
        y_o = a_i ^ b_i;
      end
      rv_isa_pkg::ALU_SLT: begin
        // One or zero in the low bit
        y_o = {{(rv_cfg_pkg::XLEN-1){1'b0}}, lt_signed};
      end
      default: begin
        y_o = '0;
      end
    endcase
  end

endmodule

// ==== exec_assert.sv ====
// Handshake and writeback checker for the execution top level
// Bound into exec_top, watches the host port and the register file write strobe

`timescale 1ns/1ps

module exec_assert (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] instr_i,
  input  logic                        req_i,
  input  logic                        ack_i,
  input  logic                        illegal_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] result_i,
  input  logic                        we_i
);

  // Failure tally
  int fail_count;

  rv_isa_pkg::instr_u word;
  logic               shift_word;

  initial begin
    fail_count = 0;
  end

  assign word = instr_i;

  // Shift encodings have a data-dependent latency
  assign shift_word = ((word.r.opcode == rv_isa_pkg::OPC_OP) ||
                       (word.r.opcode == rv_isa_pkg::OPC_OP_IMM)) &&
                      ((word.r.funct3 == rv_isa_pkg::F3_SLL) ||
                       (word.r.funct3 == rv_isa_pkg::F3_SRL));

  // Acknowledge cannot rise on an edge without a request
  ack_rise_with_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!ack_i && !req_i) |=> !ack_i
  ) else begin
    fail_count++;
    $error("ack_o rose while req_i was low");
  end

  // Acknowledge and its data hold while the host keeps the request
  ack_hold_with_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (ack_i && req_i) |=> (ack_i && $stable(result_i) && $stable(illegal_i))
  ) else begin
    fail_count++;
    $error("ack_o or its data changed before req_i fell");
  end

  // Non-shift words finish two edges after the request is seen
  two_edge_latency: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ($rose(req_i) && !shift_word) |-> !ack_i ##1 !ack_i ##1 ack_i
  ) else begin
    fail_count++;
    $error("non-shift instruction did not acknowledge after two edges");
  end

  // Writeback only happens before the acknowledge
  no_write_in_ack: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> !ack_i
  ) else begin
    fail_count++;
    $error("register write while ack_o was high");
  end

  illegal_with_ack: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    illegal_i |-> ack_i
  ) else begin
    fail_count++;
    $error("illegal_o high without ack_o");
  end

  // Reset clears every control output
  reset_clears: assert property (
    @(posedge clk_i)
    !rst_n_i |=> (!ack_i && !illegal_i && !we_i && (result_i == '0))
  ) else begin
    fail_count++;
    $error("outputs not cleared by reset");
  end

endmodule

bind exec_top exec_assert u_exec_assert (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .instr_i   (instr_i),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .illegal_i (illegal_o),
  .result_i  (result_o),
  .we_i      (rf_we)
);

// ==== exec_ctrl.sv ====
// Execution controller
// Runs the four-phase host handshake, decodes the instruction word,
// steers the ALU and serial shifter and writes the result back

`timescale 1ns/1ps

module exec_ctrl (
  // Host side
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [rv_cfg_pkg::XLEN-1:0]       instr_i,
  input  logic                              req_i,
  output logic                              ack_o,
  output logic                              illegal_o,
  output logic [rv_cfg_pkg::XLEN-1:0]       result_o,
  // Register file side
  output logic [rv_cfg_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [rv_cfg_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [rv_cfg_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [rv_cfg_pkg::XLEN-1:0]       rdata_b_i,
  output logic [rv_cfg_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic [rv_cfg_pkg::XLEN-1:0]       wdata_o,
  output logic                              we_o,
  // ALU side
  output rv_isa_pkg::alu_op_e               alu_op_o,
  output logic [rv_cfg_pkg::XLEN-1:0]       alu_b_o,
  input  logic [rv_cfg_pkg::XLEN-1:0]       alu_y_i,
  // Shift side
  output logic                              shift_load_o,
  output logic                              shift_left_o,
  output logic [rv_cfg_pkg::SHAMT_W-1:0]    shamt_o,
  input  logic                              shift_done_i,
  input  logic [rv_cfg_pkg::XLEN-1:0]       shift_data_i
);

  enum logic [1:0] {S_IDLE, S_EXEC, S_SHIFT, S_DONE} state_q, state_d;

  rv_isa_pkg::instr_u          instr_q;
  logic                        ack_q;
  logic                        illegal_q;
  logic [rv_cfg_pkg::XLEN-1:0] result_q;

  // Decode results
  logic                        legal;
  logic                        is_shift;
  logic                        use_imm;
  logic [rv_cfg_pkg::XLEN-1:0] imm_sext;
  // High on the edge that completes an instruction
  logic                        finish;

  // Capture the word when a request is accepted
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && req_i) begin
      instr_q <= instr_i;
    end
  end

  // Decode through the R-type or I-type view of the same word
  always_comb begin
    legal        = 1'b0;
    is_shift     = 1'b0;
    use_imm      = 1'b0;
    shift_left_o = 1'b0;
    alu_op_o     = rv_isa_pkg::ALU_ADD;
    case (instr_q.r.opcode)
      rv_isa_pkg::OPC_OP: begin
        case (instr_q.r.funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            legal    = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE) ||
                       (instr_q.r.funct7 == rv_isa_pkg::F7_ALT);
            alu_op_o = (instr_q.r.funct7 == rv_isa_pkg::F7_ALT) ?
                       rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
          end
          rv_isa_pkg::F3_AND: begin
            legal    = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            alu_op_o = rv_isa_pkg::ALU_AND;
          end
          rv_isa_pkg::F3_OR: begin
            legal    = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            alu_op_o = rv_isa_pkg::ALU_OR;
          end
          rv_isa_pkg::F3_XOR: begin
            legal    = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            alu_op_o = rv_isa_pkg::ALU_XOR;
          end
          rv_isa_pkg::F3_SLT: begin
            legal    = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            alu_op_o = rv_isa_pkg::ALU_SLT;
          end
          rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_SRL: begin
            legal        = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            is_shift     = 1'b1;
            shift_left_o = (instr_q.r.funct3 == rv_isa_pkg::F3_SLL);
          end
          default: begin
            legal = 1'b0;
          end
        endcase
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (instr_q.i.funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            // ADDI
            legal = 1'b1;
          end
          rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_SRL: begin
            // Upper immediate bits read as funct7, arithmetic shift rejected
            legal        = (instr_q.r.funct7 == rv_isa_pkg::F7_BASE);
            is_shift     = 1'b1;
            shift_left_o = (instr_q.i.funct3 == rv_isa_pkg::F3_SLL);
          end
          default: begin
            legal = 1'b0;
          end
        endcase
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // Operand routing
  assign raddr_a_o = instr_q.r.rs1;
  assign raddr_b_o = instr_q.r.rs2;
  assign waddr_o   = instr_q.r.rd;
  assign imm_sext  = {{(rv_cfg_pkg::XLEN-rv_isa_pkg::IMM_W){instr_q.i.imm[rv_isa_pkg::IMM_W-1]}},
                      instr_q.i.imm};
  assign alu_b_o   = use_imm ? imm_sext : rdata_b_i;

  // Shift amount from the immediate or from rs2
  assign shamt_o = use_imm ? instr_q.i.imm[rv_cfg_pkg::SHAMT_W-1:0] :
                             rdata_b_i[rv_cfg_pkg::SHAMT_W-1:0];

  // Sequencing and writeback strobe
  always_comb begin
    state_d      = state_q;
    we_o         = 1'b0;
    wdata_o      = alu_y_i;
    shift_load_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (req_i) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: begin
        if (!legal) begin
          state_d = S_DONE;
        end else if (is_shift && shamt_o != '0) begin
          shift_load_o = 1'b1;
          state_d      = S_SHIFT;
        end else begin
          // Zero-amount shift passes rs1 through unchanged
          we_o    = 1'b1;
          wdata_o = is_shift ? rdata_a_i : alu_y_i;
          state_d = S_DONE;
        end
      end
      S_SHIFT: begin
        if (shift_done_i) begin
          we_o    = 1'b1;
          wdata_o = shift_data_i;
          state_d = S_DONE;
        end
      end
      S_DONE: begin
        // Hold the acknowledge until the host withdraws
        if (!req_i) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  assign finish = (state_q != S_DONE) && (state_d == S_DONE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      ack_q     <= 1'b0;
      illegal_q <= 1'b0;
      result_q  <= '0;
    end else begin
      state_q <= state_d;
      if (finish) begin
        ack_q     <= 1'b1;
        illegal_q <= !legal;
        result_q  <= legal ? wdata_o : '0;
      end else if (state_q == S_DONE && !req_i) begin
        ack_q     <= 1'b0;
        illegal_q <= 1'b0;
      end
    end
  end

  assign ack_o     = ack_q;
  assign illegal_o = illegal_q;
  assign result_o  = result_q;

endmodule

// ==== exec_regfile.sv ====
// Register file with two asynchronous read ports and one synchronous write port
// Register zero reads as a fixed value and ignores writes

`timescale 1ns/1ps

module exec_regfile (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Read port A
  input  logic [rv_cfg_pkg::REG_ADDR_W-1:0] raddr_a_i,
  output logic [rv_cfg_pkg::XLEN-1:0]       rdata_a_o,
  // Read port B
  input  logic [rv_cfg_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_cfg_pkg::XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic [rv_cfg_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_cfg_pkg::XLEN-1:0]       wdata_i,
  input  logic                              we_i
);

  logic [rv_cfg_pkg::XLEN-1:0] mem [rv_cfg_pkg::NUM_REGS];

  // Qualified write strobe
  logic we;

  // Drop writes to register zero and while reset is held
  assign we = we_i && (waddr_i != '0) && rst_n_i;

  // Asynchronous reads, register zero forced to its fixed value
  assign rdata_a_o = (raddr_a_i == '0) ? rv_cfg_pkg::REG_ZERO_VAL : mem[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? rv_cfg_pkg::REG_ZERO_VAL : mem[raddr_b_i];

  // Write lands on the edge where the strobe is high
  always @(posedge clk_i) begin
    if (we) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Power-up contents, every slot starts at the zero value
  initial begin
    for (int k = 0; k < rv_cfg_pkg::NUM_REGS; k++) begin
      mem[k] = rv_cfg_pkg::REG_ZERO_VAL;
    end
  end

endmodule

// ==== exec_shift_count.sv ====
// Shift step counter
// Loads a shift amount, then counts down once per cycle to pace the serial shifter

`timescale 1ns/1ps

module exec_shift_count (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           load_i,
  input  logic [rv_cfg_pkg::SHAMT_W-1:0] amount_i,
  output logic                           step_o,
  output logic                           done_o
);

  logic [rv_cfg_pkg::SHAMT_W-1:0] count_q;

  // Load takes priority over counting
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= amount_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // One shift per non-zero count
  assign step_o = (count_q != '0);

  // Idle level once the count has drained
  assign done_o = (count_q == '0);

endmodule

// ==== exec_shifter.sv ====
// Bit-serial logical shifter
// Captures an operand on load and moves it one position per step, zero fill

`timescale 1ns/1ps

module exec_shifter (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        load_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] data_i,
  input  logic                        dir_left_i,
  input  logic                        step_i,
  output logic [rv_cfg_pkg::XLEN-1:0] data_o
);

  logic [rv_cfg_pkg::XLEN-1:0] data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_q <= '0;
    end else if (load_i) begin
      data_q <= data_i;
    end else if (step_i) begin
      if (dir_left_i) begin
        // Left, zero into the low bit
        data_q <= {data_q[rv_cfg_pkg::XLEN-2:0], 1'b0};
      end else begin
        // Right, zero into the high bit
        data_q <= {1'b0, data_q[rv_cfg_pkg::XLEN-1:1]};
      end
    end
  end

  assign data_o = data_q;

endmodule

// ==== exec_tb.sv ====
// Testbench for the execution subsystem
// Four-phase host driver, reference register model, value checks and report

`timescale 1ns/1ps

module exec_tb;

  // Watchdog budget, transfers times worst latency plus handshake
  localparam int MAX_XFERS     = 180;
  localparam int WORST_LATENCY = 34;
  localparam int HANDSHAKE_CYC = 8;
  localparam int CYCLE_LIMIT   = MAX_XFERS * (WORST_LATENCY + HANDSHAKE_CYC) + 50;

  logic                        clk_i;
  logic                        rst_n_i;
  logic [rv_cfg_pkg::XLEN-1:0] instr_i;
  logic                        req_i;
  logic                        ack_o;
  logic [rv_cfg_pkg::XLEN-1:0] result_o;
  logic                        illegal_o;

  // Reference register file, x0 is never written
  logic [rv_cfg_pkg::XLEN-1:0] model_regs [rv_cfg_pkg::NUM_REGS];

  logic [31:0] lfsr;
  int          cycles;
  int          checks;
  int          errors;
  int          tests_run;
  int          checks_base;
  int          errors_base;

  exec_top u_exec_top (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .instr_i   (instr_i),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .result_o  (result_o),
    .illegal_o (illegal_o)
  );

  always #20 clk_i = ~clk_i;

  // Watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // One step of a right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // n random bits, one LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] opc, input logic [6:0] f7,
                                           input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    rv_isa_pkg::instr_u w;
    w.r.opcode = opc;
    w.r.rd     = rd;
    w.r.funct3 = f3;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    w.r.funct7 = f7;
    return w;
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    rv_isa_pkg::instr_u w;
    w.i.opcode = opc;
    w.i.rd     = rd;
    w.i.funct3 = f3;
    w.i.rs1    = rs1;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // Expected result from the RV32I rules, shifts are zero fill
  function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: return sub ? (a - b) : (a + b);
      rv_isa_pkg::F3_SLL:     return a << b[4:0];
      rv_isa_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_isa_pkg::F3_XOR:     return a ^ b;
      rv_isa_pkg::F3_SRL:     return a >> b[4:0];
      rv_isa_pkg::F3_OR:      return a | b;
      rv_isa_pkg::F3_AND:     return a & b;
      default:                return '0;
    endcase
  endfunction

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error @ %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Full four-phase exchange, entered and left 2 ns after a rising edge
  task automatic exchange(input logic [31:0] word, output logic [31:0] res,
                          output logic ill);
    int hold;
    hold    = take_bits(2);
    instr_i = word;
    req_i   = 1'b1;
    @(posedge clk_i);
    #2;
    while (!ack_o) begin
      @(posedge clk_i);
      #2;
    end
    res = result_o;
    ill = illegal_o;
    // Keep the request up a few cycles to exercise back-pressure
    repeat (hold) begin
      @(posedge clk_i);
      #2;
    end
    req_i = 1'b0;
    while (ack_o) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic do_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] exp;
    logic [31:0] res;
    logic        ill;
    exp = ref_result(f3, f7 == rv_isa_pkg::F7_ALT, model_regs[rs1], model_regs[rs2]);
    exchange(encode_r(rv_isa_pkg::OPC_OP, f7, rs2, rs1, f3, rd), res, ill);
    check_word("illegal_o", {31'd0, ill}, 32'd0);
    check_word($sformatf("R-type f3=%0d f7=%h rd=x%0d", f3, f7, rd), res, exp);
    if (rd != '0) begin
      model_regs[rd] = exp;
    end
  endtask

  task automatic do_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
    logic [31:0] exp;
    logic [31:0] res;
    logic        ill;
    exp = ref_result(f3, 1'b0, model_regs[rs1], sext12(imm));
    exchange(encode_i(rv_isa_pkg::OPC_OP_IMM, imm, rs1, f3, rd), res, ill);
    check_word("illegal_o", {31'd0, ill}, 32'd0);
    check_word($sformatf("I-type f3=%0d rd=x%0d", f3, rd), res, exp);
    if (rd != '0) begin
      model_regs[rd] = exp;
    end
  endtask

  // Rejected word, then a read-back of its destination
  task automatic do_illegal(input logic [31:0] word);
    rv_isa_pkg::instr_u w;
    logic [31:0]        res;
    logic               ill;
    w = word;
    exchange(word, res, ill);
    check_word($sformatf("illegal_o for %h", word), {31'd0, ill}, 32'd1);
    do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, w.r.rd, w.r.rd, 5'd0);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("[%0t] test %0d %s: %0d checks, %0d errors", $time, tests_run, name,
             checks - checks_base, errors - errors_base);
    checks_base = checks;
    errors_base = errors;
  endtask

  initial begin
    int          sel;
    int          fails;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  amt;
    logic [6:0]  upper;
    logic [11:0] imm;
    logic [31:0] word;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    instr_i     = '0;
    req_i       = 1'b0;
    lfsr        = 32'h6dc085de;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    tests_run   = 0;
    checks_base = 0;
    errors_base = 0;
    for (int k = 0; k < rv_cfg_pkg::NUM_REGS; k++) begin
      model_regs[k] = '0;
    end

    // Reset, then one plain exchange
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    check_word("ack_o after reset", {31'd0, ack_o}, 32'd0);
    check_word("illegal_o after reset", {31'd0, illegal_o}, 32'd0);
    check_word("result_o after reset", result_o, 32'd0);
    do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd0, 5'd0, 5'd0);
    end_test("reset and handshake");

    // Load every register, then read each back through x0
    for (int r = 1; r < rv_cfg_pkg::NUM_REGS; r++) begin
      do_i(rv_isa_pkg::F3_ADD_SUB, 5'(r), 5'd0, take_bits(12));
    end
    for (int r = 1; r < rv_cfg_pkg::NUM_REGS; r++) begin
      do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'(r), 5'(r), 5'd0);
    end
    end_test("register load and read-back");

    for (int n = 0; n < 40; n++) begin
      sel = take_bits(3) % 7;
      rd  = take_bits(5);
      rs1 = take_bits(5);
      rs2 = take_bits(5);
      case (sel)
        0: do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, rd, rs1, rs2);
        1: do_r(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, rd, rs1, rs2);
        2: do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, rd, rs1, rs2);
        3: do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, rd, rs1, rs2);
        4: do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, rd, rs1, rs2);
        5: do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, rd, rs1, rs2);
        default: do_i(rv_isa_pkg::F3_ADD_SUB, rd, rs1, take_bits(12));
      endcase
    end
    end_test("ALU operations");

    // SLLI, SRLI, SLL, SRL, amounts 0 and 31 first
    for (int kind = 0; kind < 4; kind++) begin
      for (int n = 0; n < 8; n++) begin
        if (n == 0) begin
          amt = 5'd0;
        end else if (n == 1) begin
          amt = 5'd31;
        end else begin
          amt = take_bits(5);
        end
        rd  = 1 + take_bits(5) % 30;
        rs1 = 1 + take_bits(5) % 30;
        case (kind)
          0: do_i(rv_isa_pkg::F3_SLL, rd, rs1, {7'd0, amt});
          1: do_i(rv_isa_pkg::F3_SRL, rd, rs1, {7'd0, amt});
          default: begin
            // x31 carries the amount with random bits above it
            upper = take_bits(7);
            do_i(rv_isa_pkg::F3_ADD_SUB, 5'd31, 5'd0, {upper, amt});
            do_r(rv_isa_pkg::F7_BASE,
                 (kind == 2) ? rv_isa_pkg::F3_SLL : rv_isa_pkg::F3_SRL, rd, rs1, 5'd31);
          end
        endcase
      end
    end
    end_test("shifts");

    // Write to x0 shows the sum, x0 still reads zero
    imm = take_bits(12) | 12'h001;
    do_i(rv_isa_pkg::F3_ADD_SUB, 5'd0, 5'd0, imm);
    do_r(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd5, 5'd0, 5'd0);
    end_test("register zero");

    for (int n = 0; n < 6; n++) begin
      rd  = 1 + take_bits(5) % 31;
      rs1 = take_bits(5);
      rs2 = take_bits(5);
      imm = take_bits(12);
      case (n)
        0: word = encode_i(7'b0000011, imm, rs1, 3'b010, rd);
        1: word = encode_r(rv_isa_pkg::OPC_OP, 7'b0000001, rs2, rs1,
                           rv_isa_pkg::F3_ADD_SUB, rd);
        2: word = encode_r(rv_isa_pkg::OPC_OP, rv_isa_pkg::F7_ALT, rs2, rs1,
                           rv_isa_pkg::F3_XOR, rd);
        3: word = encode_r(rv_isa_pkg::OPC_OP, rv_isa_pkg::F7_BASE, rs2, rs1, 3'b011, rd);
        4: word = encode_i(rv_isa_pkg::OPC_OP_IMM, imm, rs1, 3'b011, rd);
        default: word = encode_i(rv_isa_pkg::OPC_OP_IMM, {rv_isa_pkg::F7_ALT, imm[4:0]},
                                 rs1, rv_isa_pkg::F3_SRL, rd);
      endcase
      do_illegal(word);
    end
    end_test("illegal words");

    fails = u_exec_top.u_exec_assert.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests_run, checks, errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== exec_top.sv ====
// Top level of the multi-cycle execution subsystem
// Controller, register file, ALU, shift counter and serial shifter

`timescale 1ns/1ps

module exec_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] instr_i,
  input  logic                        req_i,
  output logic                        ack_o,
  output logic [rv_cfg_pkg::XLEN-1:0] result_o,
  output logic                        illegal_o
);

  // Register file connections
  logic [rv_cfg_pkg::REG_ADDR_W-1:0] rf_raddr_a;
  logic [rv_cfg_pkg::REG_ADDR_W-1:0] rf_raddr_b;
  logic [rv_cfg_pkg::XLEN-1:0]       rf_rdata_a;
  logic [rv_cfg_pkg::XLEN-1:0]       rf_rdata_b;
  logic [rv_cfg_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [rv_cfg_pkg::XLEN-1:0]       rf_wdata;
  logic                              rf_we;

  // ALU connections
  rv_isa_pkg::alu_op_e               alu_op;
  logic [rv_cfg_pkg::XLEN-1:0]       alu_b;
  logic [rv_cfg_pkg::XLEN-1:0]       alu_y;

  // Shift path connections
  logic                              shift_load;
  logic                              shift_left;
  logic [rv_cfg_pkg::SHAMT_W-1:0]    shamt;
  logic                              shift_step;
  logic                              shift_done;
  logic [rv_cfg_pkg::XLEN-1:0]       shift_data;

  exec_ctrl u_exec_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_i      (instr_i),
    .req_i        (req_i),
    .ack_o        (ack_o),
    .illegal_o    (illegal_o),
    .result_o     (result_o),
    .raddr_a_o    (rf_raddr_a),
    .raddr_b_o    (rf_raddr_b),
    .rdata_a_i    (rf_rdata_a),
    .rdata_b_i    (rf_rdata_b),
    .waddr_o      (rf_waddr),
    .wdata_o      (rf_wdata),
    .we_o         (rf_we),
    .alu_op_o     (alu_op),
    .alu_b_o      (alu_b),
    .alu_y_i      (alu_y),
    .shift_load_o (shift_load),
    .shift_left_o (shift_left),
    .shamt_o      (shamt),
    .shift_done_i (shift_done),
    .shift_data_i (shift_data)
  );

  exec_regfile u_exec_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .rdata_a_o (rf_rdata_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_b_o (rf_rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  // First operand always comes straight from rs1
  exec_alu u_exec_alu (
    .op_i (alu_op),
    .a_i  (rf_rdata_a),
    .b_i  (alu_b),
    .y_o  (alu_y)
  );

  exec_shift_count u_exec_shift_count (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (shift_load),
    .amount_i (shamt),
    .step_o   (shift_step),
    .done_o   (shift_done)
  );

  exec_shifter u_exec_shifter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .load_i     (shift_load),
    .data_i     (rf_rdata_a),
    .dir_left_i (shift_left),
    .step_i     (shift_step),
    .data_o     (shift_data)
  );

endmodule

// ==== files.f ====
rv_cfg_pkg.sv
rv_isa_pkg.sv
exec_regfile.sv
exec_alu.sv
exec_shift_count.sv
exec_shifter.sv
exec_ctrl.sv
exec_top.sv
exec_assert.sv
exec_tb.sv

// ==== rv_cfg_pkg.sv ====
// Configuration package for the execution subsystem
// Datapath width, register file geometry and the register zero value

package rv_cfg_pkg;

  // Width of one register and of every data word
  localparam int unsigned XLEN = 32;

  // Register address width, five bits for the full RV32I file
  localparam int unsigned REG_ADDR_W = 5;

  // Number of register slots, including register zero
  localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;

  // Shift amount width, enough to cover XLEN - 1
  localparam int unsigned SHAMT_W = 5;

  // Value that register zero always returns
  localparam logic [XLEN-1:0] REG_ZERO_VAL = '0;

endpackage

// ==== rv_isa_pkg.sv ====
// Instruction set package for the execution subsystem
// Opcodes, funct fields, ALU operation codes and the two views of one instruction word

package rv_isa_pkg;

  // Accepted major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 selects the operation class
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7, base form and the alternate form used by SUB
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // I-type immediate width
  localparam int unsigned IMM_W = 12;

  // Operations of the single-step ALU
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // R-type layout, two register sources
  typedef struct packed {
    logic [6:0]                        funct7;
    logic [rv_cfg_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_cfg_pkg::REG_ADDR_W-1:0] rs1;
    logic [2:0]                        funct3;
    logic [rv_cfg_pkg::REG_ADDR_W-1:0] rd;
    logic [6:0]                        opcode;
  } instr_r_t;

  // I-type layout, one register source and a 12-bit immediate
  typedef struct packed {
    logic [IMM_W-1:0]                  imm;
    logic [rv_cfg_pkg::REG_ADDR_W-1:0] rs1;
    logic [2:0]                        funct3;
    logic [rv_cfg_pkg::REG_ADDR_W-1:0] rd;
    logic [6:0]                        opcode;
  } instr_i_t;

  // Same 32-bit word, read through either field layout
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage
